// File: verilog/drop_pkg.sv
`default_nettype none

package drop_pkg;

    // ==================================================
    // Basic widths
    // ==================================================

    typedef logic [9:0] coord_t;     // Pixel coordinate
    typedef logic [4:0] radius_t;    // Ball radius in pixels
    typedef logic [3:0] slot_idx_t;  // Slot number or ball count

    // ==================================================
    // Field geometry
    // ==================================================

    localparam radius_t NUM_BALLS   = 5'd10;     // Balls per game

    localparam coord_t  LEFT_BOUND  = 10'd20;    // Left wall
    localparam coord_t  RIGHT_BOUND = 10'd300;   // Right wall
    localparam coord_t  UP_BOUND    = 10'd50;    // Top row of the field
    localparam coord_t  FLOOR_Y     = 10'd240;   // Floor line
    localparam coord_t  START_X     = 10'd170;   // Start column of a new ball
    localparam coord_t  FALL_STEP   = 10'd3;     // Pixels per falling cycle

    // ==================================================
    // Ball radii
    // ==================================================

    localparam radius_t RADIUS_1 = 5'd5;
    localparam radius_t RADIUS_2 = 5'd10;
    localparam radius_t RADIUS_3 = 5'd15;
    localparam radius_t RADIUS_4 = 5'd20;

    // Radius handed out to each slot in turn
    localparam radius_t RADIUS_SEQ [NUM_BALLS] = '{
        RADIUS_3, RADIUS_2, RADIUS_3, RADIUS_4, RADIUS_1,
        RADIUS_2, RADIUS_3, RADIUS_4, RADIUS_2, RADIUS_3
    };

    // ==================================================
    // Compound types
    // ==================================================

    typedef struct packed {
        coord_t  x;       // Center column
        coord_t  y;       // Center row
        radius_t radius;  // Zero for an unused slot
    } ball_t;

    typedef ball_t [NUM_BALLS-1:0] ball_array_t;

    typedef enum logic [1:0] {
        AIM,   // Ball at the top, player steers it
        FALL,  // Ball dropping toward the floor
        LAND   // Ball rests on the floor for one cycle
    } player_state_t;

endpackage

`default_nettype wire

// File: verilog/drop_aim_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module drop_aim_fsm (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              left,
    input  wire logic              right,
    input  wire logic              drop,
    input  wire drop_pkg::radius_t radius,
    input  wire logic              finish,
    output drop_pkg::ball_t        player,
    output logic                   landed
);

    drop_pkg::player_state_t state_q;
    drop_pkg::player_state_t state_d;
    drop_pkg::coord_t        x_q;
    drop_pkg::coord_t        x_d;
    drop_pkg::coord_t        y_q;
    drop_pkg::coord_t        y_d;

    drop_pkg::coord_t        rad_c;
    drop_pkg::coord_t        left_lim;
    drop_pkg::coord_t        right_lim;
    drop_pkg::coord_t        floor_lim;
    drop_pkg::coord_t        top_y;
    drop_pkg::coord_t        fall_y;
    drop_pkg::coord_t        y_out;

    // ==================================================
    // Limits for the current radius
    // ==================================================

    assign rad_c     = drop_pkg::coord_t'(radius);        // Widen to coordinate
    assign left_lim  = drop_pkg::LEFT_BOUND + rad_c;      // Leftmost center
    assign right_lim = drop_pkg::RIGHT_BOUND - rad_c;     // Rightmost center
    assign floor_lim = drop_pkg::FLOOR_Y - rad_c;         // Resting row
    assign top_y     = drop_pkg::UP_BOUND - rad_c;        // Row while aiming
    assign fall_y    = y_q + drop_pkg::FALL_STEP;

    // ==================================================
    // Next state and position
    // ==================================================

    always_comb begin
        state_d = state_q;
        x_d     = x_q;
        y_d     = y_q;

        if (finish) begin
            // Game over, the ball stays parked at the top
            state_d = drop_pkg::AIM;
            y_d     = top_y;
        end else begin
            unique case (state_q)
                drop_pkg::AIM: begin
                    y_d = top_y;  // Follows a radius change at once
                    if (drop) begin
                        state_d = drop_pkg::FALL;
                    end else if (left) begin
                        if (x_q > left_lim) begin
                            x_d = x_q - 10'd1;
                        end
                    end else if (right) begin
                        if (x_q < right_lim) begin
                            x_d = x_q + 10'd1;
                        end
                    end
                end

                drop_pkg::FALL: begin
                    if (y_q >= floor_lim) begin
                        state_d = drop_pkg::LAND;  // Already on the floor
                    end else if (fall_y > floor_lim) begin
                        y_d = floor_lim;           // Last step is short
                    end else begin
                        y_d = fall_y;
                    end
                end

                drop_pkg::LAND: begin
                    state_d = drop_pkg::AIM;
                    x_d     = drop_pkg::START_X;
                    y_d     = top_y;
                end

                default: begin
                    state_d = drop_pkg::AIM;
                    x_d     = drop_pkg::START_X;
                    y_d     = top_y;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= drop_pkg::AIM;
            x_q     <= drop_pkg::START_X;
            y_q     <= drop_pkg::UP_BOUND - drop_pkg::coord_t'(drop_pkg::RADIUS_SEQ[0]);
        end else begin
            state_q <= state_d;
            x_q     <= x_d;
            y_q     <= y_d;
        end
    end

    // ==================================================
    // Outputs
    // ==================================================

    // While aiming the row comes straight from the radius, so a new ball
    // shows its own top row on the first cycle after landing
    assign y_out = (state_q == drop_pkg::AIM) ? top_y : y_q;

    assign player = '{x: x_q, y: y_out, radius: radius};
    assign landed = (state_q == drop_pkg::LAND);  // One cycle per ball

endmodule

`default_nettype wire

// File: verilog/ball_table.sv
`timescale 1ns/100ps
`default_nettype none

module ball_table (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire drop_pkg::ball_t    player,
    input  wire logic               landed,
    output drop_pkg::radius_t       radius,
    output drop_pkg::ball_array_t   balls,
    output drop_pkg::slot_idx_t     ball_count,
    output logic                    finish
);

    drop_pkg::slot_idx_t count_q;
    drop_pkg::slot_idx_t count_d;
    logic                slot_we;

    // ==================================================
    // Ball counter
    // ==================================================

    assign finish = (count_q == drop_pkg::slot_idx_t'(drop_pkg::NUM_BALLS));

    always_comb begin
        count_d = count_q;
        if (landed && !finish) begin
            count_d = count_q + 4'd1;  // Next slot after each landing
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    assign ball_count = count_q;

    // ==================================================
    // Radius of the current ball
    // ==================================================

    always_comb begin
        if (finish) begin
            radius = '0;  // No ball left to play
        end else begin
            radius = drop_pkg::RADIUS_SEQ[count_q];
        end
    end

    // ==================================================
    // Slot registers
    // ==================================================

    assign slot_we = !finish;  // Current slot tracks the live ball

    // The slot under the counter copies the live ball every cycle, so a
    // landed ball is frozen in place when the counter moves past it
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < drop_pkg::NUM_BALLS; i++) begin
                balls[i] <= '{x: drop_pkg::START_X, y: drop_pkg::UP_BOUND, radius: '0};
            end
        end else if (slot_we) begin
            balls[count_q] <= player;
        end
    end

endmodule

`default_nettype wire

// File: verilog/player_control.sv
`timescale 1ns/100ps
`default_nettype none

module player_control (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               left,
    input  wire logic               right,
    input  wire logic               drop,
    output drop_pkg::ball_array_t   balls,
    output drop_pkg::slot_idx_t     ball_count,
    output logic                    finish
);

    // ==================================================
    // Links between the FSM and the ball table
    // ==================================================

    wire drop_pkg::radius_t radius;  // Radius of the ball in play
    wire drop_pkg::ball_t   player;  // Live ball position
    wire logic              landed;  // Ball reached the floor

    // ==================================================
    // Player ball FSM
    // ==================================================

    drop_aim_fsm u_drop_aim_fsm (
        .clk    (clk),
        .rst    (rst),
        .left   (left),
        .right  (right),
        .drop   (drop),
        .radius (radius),
        .finish (finish),
        .player (player),
        .landed (landed)
    );

    // ==================================================
    // Ball slots and counter
    // ==================================================

    ball_table u_ball_table (
        .clk        (clk),
        .rst        (rst),
        .player     (player),
        .landed     (landed),
        .radius     (radius),
        .balls      (balls),
        .ball_count (ball_count),
        .finish     (finish)
    );

endmodule

`default_nettype wire

// File: dv/player_control_tb.sv
`timescale 1ns/100ps
`default_nettype none

module player_control_tb;

    // ==================================================
    // Clocking and run limits
    // ==================================================

    localparam int HALF_PERIOD  = 20;    // 40 ns clock
    localparam int RESET_CYCLES = 8;
    localparam int LAND_TIMEOUT = 200;   // Cycles allowed for one drop
    localparam int MAX_LINES    = 500;
    localparam int MAX_LINE_LEN = 256;

    logic clk   = 1'b0;
    logic rst   = 1'b1;
    logic left  = 1'b0;
    logic right = 1'b0;
    logic drop  = 1'b0;

    drop_pkg::ball_array_t balls;
    drop_pkg::slot_idx_t   ball_count;
    logic                  finish;

    int   errors  = 0;
    int   checks  = 0;
    logic aborted = 1'b0;  // Stops reading the golden file

    player_control u_player_control (
        .clk        (clk),
        .rst        (rst),
        .left       (left),
        .right      (right),
        .drop       (drop),
        .balls      (balls),
        .ball_count (ball_count),
        .finish     (finish)
    );

    initial begin
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // ==================================================
    // Compare helpers
    // ==================================================

    function automatic drop_pkg::ball_t slot_at(input int idx);
        return balls[drop_pkg::slot_idx_t'(idx)];
    endfunction

    task automatic check_int(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_ball(input string name, input drop_pkg::ball_t actual,
                              input int ex, input int ey, input int er);
        checks++;
        if (int'(actual.x) != ex || int'(actual.y) != ey || int'(actual.radius) != er) begin
            errors++;
            $display("[ERROR] %s: expected x=%0d y=%0d r=%0d, actual x=%0d y=%0d r=%0d",
                     name, ex, ey, er, actual.x, actual.y, actual.radius);
        end
    endtask

    // ==================================================
    // Button drivers
    // ==================================================

    // DUT sees the buttons high on exactly cycles rising edges
    task automatic hold_buttons(input logic hold_left, input logic hold_right, input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(posedge clk);
            left  <= hold_left;
            right <= hold_right;
        end
        @(posedge clk);
        left  <= 1'b0;
        right <= 1'b0;
    endtask

    task automatic press_drop();
        @(posedge clk);
        drop <= 1'b1;
        @(posedge clk);
        drop <= 1'b0;
    endtask

    task automatic settle();
        repeat (2) @(posedge clk);
        @(negedge clk);  // Slots are stable here
    endtask

    task automatic wait_for_landing(input int old_count, output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < LAND_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (int'(ball_count) != old_count) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic skip_line(input int fd);
        int ch;
        int n;
        ch = 0;
        n  = 0;
        while (ch != 10 && ch != -1 && n < MAX_LINE_LEN) begin
            ch = $fgetc(fd);
            n++;
        end
    endtask

    // ==================================================
    // One golden entry
    // ==================================================

    task automatic run_entry(input logic [7:0] op, input int n, input int ex,
                             input int ey, input int er, input int line_no);
        string name;
        logic  seen;
        int    old_count;
        int    i;
        name = $sformatf("line %0d (%c)", line_no, op);
        case (op)
            "L", "R", "B": begin
                hold_buttons(op != "R", op != "L", n);
                settle();
                check_ball(name, slot_at(int'(ball_count)), ex, ey, er);
            end
            "D": begin
                old_count = int'(ball_count);
                press_drop();
                wait_for_landing(old_count, seen);
                if (!seen) begin
                    $display("Timeout: ball_count stayed at %0d for %0d cycles after drop on %s",
                             old_count, LAND_TIMEOUT, name);
                    errors++;
                    aborted = 1'b1;
                end else begin
                    check_int({name, " count"}, n + 1, int'(ball_count));
                    check_ball({name, " slot"}, slot_at(n), ex, ey, er);
                end
            end
            "S": begin
                @(negedge clk);
                check_ball(name, slot_at(n), ex, ey, er);
            end
            "E": begin
                @(negedge clk);  // Before the first edge out of reset
                check_int({name, " count"}, n, int'(ball_count));
                check_int({name, " finish"}, 0, int'(finish));
                for (i = 0; i < int'(drop_pkg::NUM_BALLS); i++) begin
                    check_ball($sformatf("%s slot %0d", name, i), slot_at(i), ex, ey, er);
                end
            end
            "F": begin
                @(negedge clk);
                check_int({name, " count"}, n, int'(ball_count));
                check_int({name, " finish"}, ex, int'(finish));
            end
            "X": begin
                hold_buttons(1'b1, 1'b0, n);
                hold_buttons(1'b0, 1'b1, n);
                hold_buttons(1'b1, 1'b1, n);
                press_drop();
                settle();
            end
            default: begin
                $display("Unknown operation %c on line %0d of the golden file", op, line_no);
                errors++;
                aborted = 1'b1;
            end
        endcase
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        int         fd;
        int         code;
        int         line_no;
        int         n;
        int         ex;
        int         ey;
        int         er;
        logic [7:0] op;
        logic       at_end;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("dv/drop_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file dv/drop_golden.txt");
            errors++;
        end else begin
            line_no = 0;
            at_end  = 1'b0;
            while (!at_end && !aborted && line_no < MAX_LINES) begin
                code = $fscanf(fd, " %c", op);
                line_no++;
                if (code != 1) begin
                    at_end = 1'b1;
                end else if (op == "#") begin
                    skip_line(fd);
                end else begin
                    code = $fscanf(fd, "%d %d %d %d", n, ex, ey, er);
                    if (code != 4) begin
                        $display("Line %0d of the golden file is not a valid entry", line_no);
                        errors++;
                        aborted = 1'b1;
                    end else begin
                        run_entry(op, n, ex, ey, er, line_no);
                    end
                end
            end
            $fclose(fd);
        end

        if (checks == 0) begin
            $display("No checks were run from the golden file");
            errors++;
        end

        $display("Errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/drop_golden.txt
# op n x y radius; n = hold cycles (L R B X), slot (D S) or ball count (E F)
# L/R/B hold left/right/both, D drop, S slot, E reset state, F finish (x column = finish)
E 0 170 50 0
L 5 165 35 15
R 12 177 35 15
B 4 173 35 15
L 200 35 35 15
D 0 35 225 15
L 0 170 40 10
S 0 35 225 15
R 200 290 40 10
D 1 290 230 10
L 0 170 35 15
L 20 150 35 15
D 2 150 225 15
L 0 170 30 20
R 3 173 30 20
D 3 173 220 20
L 0 170 45 5
D 4 170 235 5
L 0 170 40 10
L 100 70 40 10
D 5 70 230 10
L 0 170 35 15
D 6 170 225 15
L 0 170 30 20
R 150 280 30 20
D 7 280 220 20
L 0 170 40 10
L 1 169 40 10
D 8 169 230 10
L 0 170 35 15
D 9 170 225 15
F 10 1 0 0
X 20 0 0 0
S 0 35 225 15
S 1 290 230 10
S 2 150 225 15
S 3 173 220 20
S 4 170 235 5
S 5 70 230 10
S 6 170 225 15
S 7 280 220 20
S 8 169 230 10
S 9 170 225 15
F 10 1 0 0

// File: build.f
verilog/drop_pkg.sv
verilog/drop_aim_fsm.sv
verilog/ball_table.sv
verilog/player_control.sv
dv/player_control_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the player_control testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=player_control_tb
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timing --top-module "$TOP" --Mdir "$BUILD_DIR" -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation binary exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
